// ==== Bender.yml ====
package:
  name: afifo

sources:
  - afifo_pkg.sv
  - cdc_bit_sync.sv
  - ram_sdp2c.sv
  - afifo_wr_ptr.sv
  - afifo_rd_ptr.sv
  - afifo_core.sv
  - target: test
    files:
      - afifo_tb.sv

// ==== afifo.f ====
afifo_pkg.sv
cdc_bit_sync.sv
ram_sdp2c.sv
afifo_wr_ptr.sv
afifo_rd_ptr.sv
afifo_core.sv
afifo_tb.sv

// ==== afifo_core.sv ====
// Dual-clock FIFO top level
`timescale 1ns/100ps

module afifo_core #(
  parameter int DATA_WIDTH_P = 32,
  parameter int ADDR_WIDTH_P = 4
) (
  // write domain
  input  logic                    wclk,
  input  logic                    rst_w_n,
  input  logic                    wr_en,
  input  logic [DATA_WIDTH_P-1:0] wr_data,
  output logic                    full,
  output logic [ADDR_WIDTH_P:0]   wr_level,
  // read domain
  input  logic                    rclk,
  input  logic                    rst_r_n,
  input  logic                    rd_en,
  output logic [DATA_WIDTH_P-1:0] rd_data,
  output logic                    empty,
  output logic [ADDR_WIDTH_P:0]   rd_level
);

  // write domain
  logic                    wr_done;
  logic [ADDR_WIDTH_P:0]   wr_gray;
  logic                    rd_done_sync;
  logic [ADDR_WIDTH_P:0]   rd_gray_sync;
  logic                    mem_wr_en;
  logic [ADDR_WIDTH_P-1:0] mem_wr_addr;

  // read domain
  logic                    rd_done;
  logic [ADDR_WIDTH_P:0]   rd_gray;
  logic                    wr_done_sync;
  logic [ADDR_WIDTH_P:0]   wr_gray_sync;
  logic [ADDR_WIDTH_P-1:0] rd_addr_next;

  // --------------------------------------------------------------------------
  // pointer blocks
  // --------------------------------------------------------------------------

  afifo_wr_ptr #(
    .ADDR_WIDTH_P (ADDR_WIDTH_P)
  ) i_wr_ptr (
    .wclk         (wclk),
    .rst_w_n      (rst_w_n),
    .wr_en        (wr_en),
    .rd_done_sync (rd_done_sync),
    .rd_gray_sync (rd_gray_sync),
    .wr_done      (wr_done),
    .wr_gray      (wr_gray),
    .mem_wr_en    (mem_wr_en),
    .mem_wr_addr  (mem_wr_addr),
    .full         (full),
    .wr_level     (wr_level)
  );

  afifo_rd_ptr #(
    .ADDR_WIDTH_P (ADDR_WIDTH_P)
  ) i_rd_ptr (
    .rclk         (rclk),
    .rst_r_n      (rst_r_n),
    .rd_en        (rd_en),
    .wr_done_sync (wr_done_sync),
    .wr_gray_sync (wr_gray_sync),
    .rd_done      (rd_done),
    .rd_gray      (rd_gray),
    .rd_addr_next (rd_addr_next),
    .empty        (empty),
    .rd_level     (rd_level)
  );

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------

  ram_sdp2c #(
    .DATA_WIDTH_P (DATA_WIDTH_P),
    .ADDR_WIDTH_P (ADDR_WIDTH_P)
  ) i_ram (
    .clk_a   (wclk),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (wr_data),
    .clk_b   (rclk),
    .rd_addr (rd_addr_next),
    .rd_data (rd_data)
  );

  // --------------------------------------------------------------------------
  // clock domain crossings
  // --------------------------------------------------------------------------

  // every chain is afifo_pkg::SYNC_STAGES_C flops deep, so each flag sees
  // the other side that many edges late plus one for the flag register

  cdc_bit_sync i_sync_wr_done (
    .clk_dst   (rclk),
    .rst_dst_n (rst_r_n),
    .src_bit   (wr_done),
    .dst_bit   (wr_done_sync)
  );

  cdc_bit_sync i_sync_rd_done (
    .clk_dst   (wclk),
    .rst_dst_n (rst_w_n),
    .src_bit   (rd_done),
    .dst_bit   (rd_done_sync)
  );

  // Gray pointers change one bit per step, so per-bit chains are safe
  for (genvar i = 0; i <= ADDR_WIDTH_P; i++) begin : g_wr_gray_sync
    cdc_bit_sync i_sync (
      .clk_dst   (rclk),
      .rst_dst_n (rst_r_n),
      .src_bit   (wr_gray[i]),
      .dst_bit   (wr_gray_sync[i])
    );
  end

  for (genvar i = 0; i <= ADDR_WIDTH_P; i++) begin : g_rd_gray_sync
    cdc_bit_sync i_sync (
      .clk_dst   (wclk),
      .rst_dst_n (rst_w_n),
      .src_bit   (rd_gray[i]),
      .dst_bit   (rd_gray_sync[i])
    );
  end

endmodule

// ==== afifo_pkg.sv ====
// Dual-clock FIFO shared definitions

package afifo_pkg;

  // --------------------------------------------------------------------------
  // clock domain crossing
  // --------------------------------------------------------------------------

  // flip-flops in every synchronizer chain
  localparam int SYNC_STAGES_C = 2;

  // --------------------------------------------------------------------------
  // link state of each pointer side
  // --------------------------------------------------------------------------

  // a side may only move its pointer once the other domain is out of reset
  typedef enum logic [1:0] {
    // own reset asserted
    LINK_RESET = 2'd0,
    // own reset released, other side not yet seen
    LINK_WAIT  = 2'd1,
    // both domains running, pointer may move
    LINK_UP    = 2'd2
  } link_state_t;

endpackage

// ==== afifo_rd_ptr.sv ====
// FIFO read pointer and empty flag
`timescale 1ns/100ps

module afifo_rd_ptr
  import afifo_pkg::*;
#(
  parameter int ADDR_WIDTH_P = 4
) (
  input  logic                    rclk,
  input  logic                    rst_r_n,
  input  logic                    rd_en,
  // write side state, already in the rclk domain
  input  logic                    wr_done_sync,
  input  logic [ADDR_WIDTH_P:0]   wr_gray_sync,
  output logic                    rd_done,
  output logic [ADDR_WIDTH_P:0]   rd_gray,
  // RAM read address, taken from the next pointer
  output logic [ADDR_WIDTH_P-1:0] rd_addr_next,
  output logic                    empty,
  output logic [ADDR_WIDTH_P:0]   rd_level
);

  link_state_t           link_state;
  link_state_t           link_state_next;
  logic                  link_go;
  logic                  rd_accept;
  logic [ADDR_WIDTH_P:0] rd_bin;
  logic [ADDR_WIDTH_P:0] rd_bin_next;
  logic [ADDR_WIDTH_P:0] rd_gray_next;
  logic [ADDR_WIDTH_P:0] wr_bin_sync;
  logic                  empty_next;

  // --------------------------------------------------------------------------
  // link FSM
  // --------------------------------------------------------------------------

  always_comb begin
    link_state_next = link_state;
    case (link_state)
      LINK_RESET: link_state_next = LINK_WAIT;
      LINK_WAIT: begin
        if (wr_done_sync) begin
          link_state_next = LINK_UP;
        end
      end
      LINK_UP: link_state_next = LINK_UP;
      default: link_state_next = LINK_RESET;
    endcase
  end

  assign link_go = (link_state_next == LINK_UP);

  // --------------------------------------------------------------------------
  // pointer and empty flag
  // --------------------------------------------------------------------------

  assign rd_accept    = rd_en && !empty;
  assign rd_bin_next  = rd_bin + {{ADDR_WIDTH_P{1'b0}}, rd_accept};
  assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

  // caught up with the writer
  assign empty_next = (rd_gray_next == wr_gray_sync);

  // show-ahead: the RAM register loads the word the new pointer points at
  assign rd_addr_next = rd_bin_next[ADDR_WIDTH_P-1:0];

  always_ff @(posedge rclk or negedge rst_r_n) begin
    if (!rst_r_n) begin
      link_state <= LINK_RESET;
      rd_done    <= 1'b0;
      rd_bin     <= '0;
      rd_gray    <= '0;
      empty      <= 1'b1;
    end else begin
      link_state <= link_state_next;
      rd_done    <= 1'b1;
      if (link_go) begin
        rd_bin  <= rd_bin_next;
        rd_gray <= rd_gray_next;
        empty   <= empty_next;
      end
    end
  end

  // --------------------------------------------------------------------------
  // fill level
  // --------------------------------------------------------------------------

  always_comb begin
    wr_bin_sync[ADDR_WIDTH_P] = wr_gray_sync[ADDR_WIDTH_P];
    for (int i = ADDR_WIDTH_P - 1; i >= 0; i--) begin
      wr_bin_sync[i] = wr_bin_sync[i+1] ^ wr_gray_sync[i];
    end
  end

  always_ff @(posedge rclk or negedge rst_r_n) begin
    if (!rst_r_n) begin
      rd_level <= '0;
    end else begin
      // lags the writer by the crossing, so it never over-reports
      rd_level <= wr_bin_sync - rd_bin;
    end
  end

endmodule

// ==== afifo_stim.txt ====
# one command per line: PUSH hex_word | BURST n | POP n | DRAIN | IDLE n | FLOOD n
# EXPECT full empty wr_level rd_level (checked after the preceding commands)
POP 4
IDLE 10
EXPECT 0 1 0 0
PUSH 1a2b
PUSH 3c4d
PUSH 5e6f
IDLE 10
EXPECT 0 0 3 3
POP 2
IDLE 10
BURST 5
IDLE 10
EXPECT 0 0 6 6
DRAIN
IDLE 10
EXPECT 0 1 0 0
BURST 8
IDLE 10
EXPECT 1 0 8 8
PUSH dead
IDLE 10
EXPECT 1 0 8 8
DRAIN
IDLE 10
EXPECT 0 1 0 0
# pointer wrap
BURST 7
POP 5
IDLE 12
BURST 6
POP 7
IDLE 12
BURST 9
DRAIN
IDLE 10
FLOOD 200
IDLE 12
DRAIN
IDLE 10
EXPECT 0 1 0 0
FLOOD 150
IDLE 10
DRAIN
IDLE 10
EXPECT 0 1 0 0

// ==== afifo_tb.sv ====
// Dual-clock FIFO testbench
`timescale 1ns/100ps

module afifo_tb;

  localparam int DATA_W = 16;
  localparam int ADDR_W = 3;

  logic              wclk;
  logic              rclk;
  logic              rst_w_n;
  logic              rst_r_n;
  logic              wr_en;
  logic              rd_en;
  logic [DATA_W-1:0] wr_data;
  logic [DATA_W-1:0] rd_data;
  logic              full;
  logic              empty;
  logic [ADDR_W:0]   wr_level;
  logic [ADDR_W:0]   rd_level;

  // reference contents, oldest word at the front
  logic [DATA_W-1:0] model_q[$];
  int                cycle_count;
  int                cycle_limit;
  string             cmd_s;
  int                arg_v[4];

  afifo_core #(
    .DATA_WIDTH_P (DATA_W),
    .ADDR_WIDTH_P (ADDR_W)
  ) i_afifo_core (
    .wclk     (wclk),
    .rst_w_n  (rst_w_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .wr_level (wr_level),
    .rclk     (rclk),
    .rst_r_n  (rst_r_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty),
    .rd_level (rd_level)
  );

  // rising edges never coincide: rclk at 4k+2, wclk at 6k+3
  initial begin
    rclk = 1'b0;
    forever #2 rclk = ~rclk;
  end

  initial begin
    wclk = 1'b0;
    forever #3 wclk = ~wclk;
  end

  always @(posedge rclk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: the stimulus did not finish within %0d read clock cycles", cycle_limit);
      stop_run();
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_level(input string name, input logic [ADDR_W:0] exp,
                             input logic [ADDR_W:0] act);
    if (act !== exp) begin
      $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // bus cycles, each side samples its own outputs 1 ns after its own edge
  // --------------------------------------------------------------------------

  task automatic write_cycle(input logic en, input logic [DATA_W-1:0] d);
    @(posedge wclk);
    #1;
    if (en && !full) begin
      model_q.push_back(d);
    end
    wr_en   = en;
    wr_data = d;
  endtask

  task automatic read_cycle(input logic en);
    @(posedge rclk);
    #1;
    if (en && !empty) begin
      if (model_q.size() == 0) begin
        $display("a read was accepted while the model held no word");
        stop_run();
      end
      check_data("rd_data", model_q.pop_front(), rd_data);
    end
    rd_en = en;
  endtask

  task automatic idle_cycles(input int n);
    fork
      repeat (n) @(posedge wclk);
      repeat (n) @(posedge rclk);
    join
    if (n >= 10) begin
      @(posedge wclk);
      #1;
      check_level("wr_level", (ADDR_W + 1)'(model_q.size()), wr_level);
      @(posedge rclk);
      #1;
      check_level("rd_level", (ADDR_W + 1)'(model_q.size()), rd_level);
    end
  endtask

  task automatic flood(input int n);
    fork
      begin
        repeat (n) write_cycle(1'($urandom % 2), DATA_W'($urandom));
        write_cycle(1'b0, '0);
      end
      begin
        repeat (n) read_cycle(1'($urandom % 2));
        read_cycle(1'b0);
      end
    join
  endtask

  task automatic expect_state();
    @(posedge wclk);
    #1;
    check_flag("full", 1'(arg_v[0]), full);
    check_level("wr_level", (ADDR_W + 1)'(arg_v[2]), wr_level);
    @(posedge rclk);
    #1;
    check_flag("empty", 1'(arg_v[1]), empty);
    check_level("rd_level", (ADDR_W + 1)'(arg_v[3]), rd_level);
  endtask

  // --------------------------------------------------------------------------
  // stimulus file
  // --------------------------------------------------------------------------

  // next command into cmd_s and arg_v, comment lines start with #
  task automatic read_command(input int fd, output bit got);
    string line;
    int    n;
    bit    done;
    bit    bad;
    got  = 1'b0;
    done = 1'b0;
    while (!got && !done) begin
      n = $fscanf(fd, "%s", cmd_s);
      if (n != 1) begin
        done = 1'b1;
      end else if (cmd_s.substr(0, 0) == "#") begin
        n = $fgets(line, fd);
      end else begin
        got = 1'b1;
        case (cmd_s)
          "PUSH":   bad = ($fscanf(fd, "%h", arg_v[0]) != 1);
          "BURST", "POP", "IDLE", "FLOOD": bad = ($fscanf(fd, "%d", arg_v[0]) != 1);
          "EXPECT": begin
            n   = $fscanf(fd, "%d %d %d %d", arg_v[0], arg_v[1], arg_v[2], arg_v[3]);
            bad = (n != 4);
          end
          "DRAIN":  bad = 1'b0;
          default: begin
            $display("unknown command %s in the stimulus file", cmd_s);
            stop_run();
          end
        endcase
        if (bad) begin
          $display("missing arguments after %s in the stimulus file", cmd_s);
          stop_run();
        end
      end
    end
  endtask

  initial begin
    int fd;
    bit got;
    int total;
    logic up;
    rst_w_n     = 1'b0;
    rst_r_n     = 1'b0;
    wr_en       = 1'b0;
    rd_en       = 1'b0;
    wr_data     = '0;
    cycle_count = 0;
    cycle_limit = 0;
    total       = 0;
    void'($urandom(27952));

    // first pass sizes the timeout
    fd = $fopen("afifo_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file afifo_stim.txt");
      stop_run();
    end
    read_command(fd, got);
    while (got) begin
      if (cmd_s == "BURST" || cmd_s == "POP" || cmd_s == "IDLE" || cmd_s == "FLOOD") begin
        total += arg_v[0];
      end else begin
        total += 1;
      end
      read_command(fd, got);
    end
    $fclose(fd);
    cycle_limit = total * 16 + 500;

    // reset and link-up
    repeat (8) @(posedge rclk);
    #1;
    check_flag("full", 1'b1, full);
    check_flag("empty", 1'b1, empty);
    check_level("wr_level", '0, wr_level);
    check_level("rd_level", '0, rd_level);
    repeat (8) @(posedge rclk);
    #1;
    rst_w_n = 1'b1;
    rst_r_n = 1'b1;
    up = 1'b0;
    for (int i = 0; i < 20 && !up; i++) begin
      @(posedge wclk);
      #1;
      // the first edge only leaves LINK_RESET, so full is still up
      if (i == 0) begin
        check_flag("full", 1'b1, full);
      end
      check_level("wr_level", '0, wr_level);
      up = !full;
    end
    if (!up) begin
      $display("full did not fall within 20 write clock cycles after reset");
      stop_run();
    end
    @(posedge rclk);
    #1;
    check_flag("empty", 1'b1, empty);
    check_level("rd_level", '0, rd_level);

    fd = $fopen("afifo_stim.txt", "r");
    read_command(fd, got);
    while (got) begin
      case (cmd_s)
        "PUSH": begin
          write_cycle(1'b1, DATA_W'(arg_v[0]));
          write_cycle(1'b0, '0);
        end
        "BURST": begin
          repeat (arg_v[0]) write_cycle(1'b1, DATA_W'($urandom));
          write_cycle(1'b0, '0);
        end
        "POP": begin
          repeat (arg_v[0]) read_cycle(1'b1);
          read_cycle(1'b0);
        end
        "DRAIN": begin
          while (model_q.size() != 0) read_cycle(1'b1);
          read_cycle(1'b0);
        end
        "IDLE":   idle_cycles(arg_v[0]);
        "FLOOD":  flood(arg_v[0]);
        "EXPECT": expect_state();
        default:  ;
      endcase
      read_command(fd, got);
    end
    $fclose(fd);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== afifo_wr_ptr.sv ====
// FIFO write pointer and full flag
`timescale 1ns/100ps

module afifo_wr_ptr
  import afifo_pkg::*;
#(
  parameter int ADDR_WIDTH_P = 4
) (
  input  logic                    wclk,
  input  logic                    rst_w_n,
  input  logic                    wr_en,
  // read side state, already in the wclk domain
  input  logic                    rd_done_sync,
  input  logic [ADDR_WIDTH_P:0]   rd_gray_sync,
  output logic                    wr_done,
  output logic [ADDR_WIDTH_P:0]   wr_gray,
  // RAM write port
  output logic                    mem_wr_en,
  output logic [ADDR_WIDTH_P-1:0] mem_wr_addr,
  output logic                    full,
  output logic [ADDR_WIDTH_P:0]   wr_level
);

  link_state_t           link_state;
  link_state_t           link_state_next;
  logic                  link_go;
  logic                  wr_accept;
  logic [ADDR_WIDTH_P:0] wr_bin;
  logic [ADDR_WIDTH_P:0] wr_bin_next;
  logic [ADDR_WIDTH_P:0] wr_gray_next;
  logic [ADDR_WIDTH_P:0] rd_bin_sync;
  logic                  full_next;

  // --------------------------------------------------------------------------
  // link FSM
  // --------------------------------------------------------------------------

  always_comb begin
    link_state_next = link_state;
    case (link_state)
      LINK_RESET: link_state_next = LINK_WAIT;
      LINK_WAIT: begin
        if (rd_done_sync) begin
          link_state_next = LINK_UP;
        end
      end
      LINK_UP: link_state_next = LINK_UP;
      default: link_state_next = LINK_RESET;
    endcase
  end

  // registers follow the pointer logic from the edge that enters LINK_UP
  assign link_go = (link_state_next == LINK_UP);

  // --------------------------------------------------------------------------
  // pointer and full flag
  // --------------------------------------------------------------------------

  // full stays high until the link is up, so no write slips in early
  assign wr_accept    = wr_en && !full;
  assign wr_bin_next  = wr_bin + {{ADDR_WIDTH_P{1'b0}}, wr_accept};
  assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

  // one full lap ahead of the reader: two top Gray bits differ
  assign full_next = (wr_gray_next == {~rd_gray_sync[ADDR_WIDTH_P:ADDR_WIDTH_P-1],
                                       rd_gray_sync[ADDR_WIDTH_P-2:0]});

  assign mem_wr_en   = wr_accept;
  assign mem_wr_addr = wr_bin[ADDR_WIDTH_P-1:0];

  always_ff @(posedge wclk or negedge rst_w_n) begin
    if (!rst_w_n) begin
      link_state <= LINK_RESET;
      wr_done    <= 1'b0;
      wr_bin     <= '0;
      wr_gray    <= '0;
      full       <= 1'b1;
    end else begin
      link_state <= link_state_next;
      wr_done    <= 1'b1;
      if (link_go) begin
        wr_bin  <= wr_bin_next;
        wr_gray <= wr_gray_next;
        full    <= full_next;
      end
    end
  end

  // --------------------------------------------------------------------------
  // fill level
  // --------------------------------------------------------------------------

  // gray to binary, XOR prefix from the top bit down
  always_comb begin
    rd_bin_sync[ADDR_WIDTH_P] = rd_gray_sync[ADDR_WIDTH_P];
    for (int i = ADDR_WIDTH_P - 1; i >= 0; i--) begin
      rd_bin_sync[i] = rd_bin_sync[i+1] ^ rd_gray_sync[i];
    end
  end

  // modular difference, wraps with the extra pointer bit
  always_ff @(posedge wclk or negedge rst_w_n) begin
    if (!rst_w_n) begin
      wr_level <= '0;
    end else begin
      wr_level <= wr_bin - rd_bin_sync;
    end
  end

endmodule

// ==== cdc_bit_sync.sv ====
// Single-bit synchronizer
`timescale 1ns/100ps

module cdc_bit_sync
  import afifo_pkg::*;
(
  input  logic clk_dst,
  input  logic rst_dst_n,
  input  logic src_bit,
  output logic dst_bit
);

  // stage 0 is the metastable capture flop
  logic [SYNC_STAGES_C-1:0] sync_q;

  always_ff @(posedge clk_dst or negedge rst_dst_n) begin
    if (!rst_dst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES_C-2:0], src_bit};
    end
  end

  // last stage is safe to use in the destination domain
  assign dst_bit = sync_q[SYNC_STAGES_C-1];

endmodule

// ==== ram_sdp2c.sv ====
// Two-clock simple dual-port RAM
`timescale 1ns/100ps

module ram_sdp2c #(
  parameter int DATA_WIDTH_P = 32,
  parameter int ADDR_WIDTH_P = 4
) (
  // write port
  input  logic                    clk_a,
  input  logic                    wr_en,
  input  logic [ADDR_WIDTH_P-1:0] wr_addr,
  input  logic [DATA_WIDTH_P-1:0] wr_data,
  // read port
  input  logic                    clk_b,
  input  logic [ADDR_WIDTH_P-1:0] rd_addr,
  output logic [DATA_WIDTH_P-1:0] rd_data
);

  localparam int DEPTH_C = 2 ** ADDR_WIDTH_P;

  logic [DATA_WIDTH_P-1:0] mem [DEPTH_C];

  always_ff @(posedge clk_a) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read on every edge, one cycle of latency
  always_ff @(posedge clk_b) begin
    rd_data <= mem[rd_addr];
  end

endmodule
